/* include/stream_params.svh */
`ifndef STREAM_PARAMS_SVH
`define STREAM_PARAMS_SVH

// Width of one stream word
`define STREAM_DATA_WIDTH 32

// Skid buffer depth select, 1 is four-deep and 0 is two-deep
`define STREAM_IN_SKID4   1
`define STREAM_OUT_SKID4  0

`endif

/* source/stream_pkg.sv */
`include "stream_params.svh"

package stream_pkg;

    // One word on the stream
    typedef logic [`STREAM_DATA_WIDTH-1:0] stream_word_t;

    // Packet sum, wraps modulo 2^32
    typedef logic [`STREAM_DATA_WIDTH-1:0] checksum_t;

    // Inserter FSM
    typedef enum logic {
        PASS,
        APPEND
    } inserter_state_e;

endpackage : stream_pkg

/* source/stream_if.sv */
`timescale 1ns/100ps

interface stream_if import stream_pkg::*; ();

    logic         valid;
    logic         ready;
    stream_word_t data;
    logic         last;

    modport source (
        output valid,
        output data,
        output last,
        input  ready
    );

    modport sink (
        input  valid,
        input  data,
        input  last,
        output ready
    );

endinterface : stream_if

/* source/axi_skid_buffer.sv */
`timescale 1ns/100ps
`include "stream_params.svh"

module axi_skid_buffer #(
    parameter int DATA_WIDTH = `STREAM_DATA_WIDTH + 1,
    parameter int SKID4      = 0
) (
    input  logic    i_axi_aclk,
    input  logic    i_axi_aresetn,
    stream_if.sink  i_wr,
    stream_if.source o_rd
);
    localparam int DW = DATA_WIDTH;

    // Occupancy at which write ready drops
    localparam logic [2:0] FULL_COUNT = (SKID4 != 0) ? 3'd4 : 3'd2;

    logic          r_wr_ready;
    logic          r_rd_valid;
    logic [2:0]    r_count;
    logic [DW-1:0] r_data;
    logic [DW-1:0] w_wr_word;
    logic          w_wr_xfer;
    logic          w_rd_xfer;
    logic          w_wr_ready_nxt;
    logic          w_rd_valid_nxt;

    // Last mark rides in the top bit
    assign w_wr_word = {i_wr.last, i_wr.data};

    assign w_wr_xfer = i_wr.valid & r_wr_ready;
    assign w_rd_xfer = r_rd_valid & o_rd.ready;

    assign w_wr_ready_nxt = (r_count < FULL_COUNT - 3'd1) ||
                            (r_count == FULL_COUNT - 3'd1 && (~w_wr_xfer || w_rd_xfer)) ||
                            (r_count == FULL_COUNT && w_rd_xfer);

    assign w_rd_valid_nxt = (r_count > 3'd1) ||
                            (r_count == 3'd1 && (~w_rd_xfer || w_wr_xfer)) ||
                            (r_count == 3'd0 && w_wr_xfer);

    always_ff @(posedge i_axi_aclk or negedge i_axi_aresetn) begin
        if (~i_axi_aresetn) begin
            r_wr_ready <= 1'b0;
            r_rd_valid <= 1'b0;
            r_count    <= 3'd0;
        end else begin
            r_wr_ready <= w_wr_ready_nxt;
            r_rd_valid <= w_rd_valid_nxt;
            if (w_wr_xfer && !w_rd_xfer) begin
                r_count <= r_count + 3'd1;
            end else if (!w_wr_xfer && w_rd_xfer) begin
                r_count <= r_count - 3'd1;
            end
        end
    end

    generate
        if (SKID4 != 0) begin : gen_skid4
            logic [DW-1:0] r_skid1;
            logic [DW-1:0] r_skid2;
            logic [DW-1:0] r_skid3;

            // r_data is the head, skid registers hold the words behind it
            always_ff @(posedge i_axi_aclk) begin
                case (r_count)
                    3'd0: begin
                        if (w_wr_xfer) begin
                            r_data <= w_wr_word;
                        end
                    end
                    3'd1: begin
                        if (w_rd_xfer) begin
                            r_data <= w_wr_word;
                        end
                        if (w_wr_xfer) begin
                            r_skid1 <= w_wr_word;
                        end
                    end
                    3'd2: begin
                        if (w_rd_xfer) begin
                            r_data <= r_skid1;
                        end
                        if (w_wr_xfer && w_rd_xfer) begin
                            r_skid1 <= w_wr_word;
                        end else if (w_wr_xfer) begin
                            r_skid2 <= w_wr_word;
                        end
                    end
                    3'd3: begin
                        if (w_rd_xfer) begin
                            r_data  <= r_skid1;
                            r_skid1 <= r_skid2;
                            r_skid2 <= w_wr_word;
                        end
                    end
                    3'd4: begin
                        if (w_rd_xfer) begin
                            r_data  <= r_skid1;
                            r_skid1 <= r_skid2;
                            r_skid2 <= r_skid3;
                        end
                    end
                    default: ;
                endcase

                // Fourth slot only matters when going from three to four
                if (w_wr_xfer) begin
                    r_skid3 <= w_wr_word;
                end
            end
        end else begin : gen_skid2
            logic [DW-1:0] r_skid1;

            always_ff @(posedge i_axi_aclk) begin
                case (r_count)
                    3'd0: begin
                        if (w_wr_xfer) begin
                            r_data <= w_wr_word;
                        end
                    end
                    3'd1: begin
                        // Pass-through when reading and writing together
                        if (w_rd_xfer) begin
                            r_data <= w_wr_word;
                        end
                    end
                    3'd2: begin
                        if (w_rd_xfer) begin
                            r_data <= r_skid1;
                        end
                    end
                    default: ;
                endcase

                if (w_wr_xfer) begin
                    r_skid1 <= w_wr_word;
                end
            end
        end
    endgenerate

    assign i_wr.ready = r_wr_ready;
    assign o_rd.valid = r_rd_valid;
    assign o_rd.data  = r_data[DW-2:0];
    assign o_rd.last  = r_data[DW-1];

endmodule : axi_skid_buffer

/* source/checksum_inserter.sv */
`timescale 1ns/100ps

module checksum_inserter import stream_pkg::*; (
    input  logic     i_axi_aclk,
    input  logic     i_axi_aresetn,
    stream_if.sink   i_pkt,
    stream_if.source o_pkt
);
    inserter_state_e r_state;
    checksum_t       r_sum;
    checksum_t       r_final;
    checksum_t       w_sum_nxt;
    logic            w_in_xfer;
    logic            w_out_xfer;

    assign w_in_xfer  = i_pkt.valid & i_pkt.ready;
    assign w_out_xfer = o_pkt.valid & o_pkt.ready;

    // Wraps modulo 2^32
    assign w_sum_nxt = r_sum + i_pkt.data;

    // Combinational path in PASS, checksum word in APPEND
    assign o_pkt.valid = (r_state == PASS) ? i_pkt.valid : 1'b1;
    assign o_pkt.data  = (r_state == PASS) ? i_pkt.data  : r_final;
    assign o_pkt.last  = (r_state == APPEND);
    assign i_pkt.ready = (r_state == PASS) ? o_pkt.ready : 1'b0;

    always_ff @(posedge i_axi_aclk or negedge i_axi_aresetn) begin
        if (~i_axi_aresetn) begin
            r_state <= PASS;
            r_sum   <= '0;
        end else begin
            case (r_state)
                PASS: begin
                    if (w_in_xfer) begin
                        if (i_pkt.last) begin
                            r_sum   <= '0;
                            r_state <= APPEND;
                        end else begin
                            r_sum <= w_sum_nxt;
                        end
                    end
                end
                APPEND: begin
                    if (w_out_xfer) begin
                        r_state <= PASS;
                    end
                end
                default: r_state <= PASS;
            endcase
        end
    end

    // Final sum includes the last word itself
    always_ff @(posedge i_axi_aclk) begin
        if (w_in_xfer && i_pkt.last) begin
            r_final <= w_sum_nxt;
        end
    end

endmodule : checksum_inserter

/* source/stream_checksum_top.sv */
`timescale 1ns/100ps
`include "stream_params.svh"

module stream_checksum_top import stream_pkg::*; (
    input  logic         i_axi_aclk,
    input  logic         i_axi_aresetn,

    // Upstream side
    input  logic         i_s_valid,
    output logic         o_s_ready,
    input  stream_word_t i_s_data,
    input  logic         i_s_last,

    // Downstream side
    output logic         o_m_valid,
    input  logic         i_m_ready,
    output stream_word_t o_m_data,
    output logic         o_m_last
);
    stream_if port_in  ();
    stream_if link_in  ();
    stream_if link_out ();
    stream_if port_out ();

    assign port_in.valid = i_s_valid;
    assign port_in.data  = i_s_data;
    assign port_in.last  = i_s_last;
    assign o_s_ready     = port_in.ready;

    assign o_m_valid      = port_out.valid;
    assign o_m_data       = port_out.data;
    assign o_m_last       = port_out.last;
    assign port_out.ready = i_m_ready;

    // Buffers carry the last mark as an extra data bit
    axi_skid_buffer #(
        .DATA_WIDTH (`STREAM_DATA_WIDTH + 1),
        .SKID4      (`STREAM_IN_SKID4)
    ) u_in_skid (
        .i_axi_aclk    (i_axi_aclk),
        .i_axi_aresetn (i_axi_aresetn),
        .i_wr          (port_in.sink),
        .o_rd          (link_in.source)
    );

    checksum_inserter u_inserter (
        .i_axi_aclk    (i_axi_aclk),
        .i_axi_aresetn (i_axi_aresetn),
        .i_pkt         (link_in.sink),
        .o_pkt         (link_out.source)
    );

    axi_skid_buffer #(
        .DATA_WIDTH (`STREAM_DATA_WIDTH + 1),
        .SKID4      (`STREAM_OUT_SKID4)
    ) u_out_skid (
        .i_axi_aclk    (i_axi_aclk),
        .i_axi_aresetn (i_axi_aresetn),
        .i_wr          (link_out.sink),
        .o_rd          (port_out.source)
    );

endmodule : stream_checksum_top

/* verif/stream_checksum_checker.sv */
`timescale 1ns/100ps

module stream_checksum_checker import stream_pkg::*; (
    input  logic            i_axi_aclk,
    input  logic            i_axi_aresetn,
    input  logic            i_m_valid,
    input  logic            i_m_ready,
    input  stream_word_t    i_m_data,
    input  logic            i_m_last,
    input  inserter_state_e i_state,
    input  logic            i_ins_valid,
    input  stream_word_t    i_ins_data,
    input  logic            i_ins_last,
    input  logic            i_link_valid,
    input  logic            i_link_ready
);
    // Count of failed assertions
    int fail_count = 0;

    // Output word held until the sink takes it
    hold_output_a: assert property (@(posedge i_axi_aclk) disable iff (!i_axi_aresetn)
        i_m_valid && !i_m_ready |=> i_m_valid && $stable(i_m_data) && $stable(i_m_last))
    else begin
        $error("output word changed or vanished while stalled");
        fail_count++;
    end

    // Waiting input word stays in the input buffer while the checksum word is pending
    append_holds_input_a: assert property (@(posedge i_axi_aclk) disable iff (!i_axi_aresetn)
        i_state == APPEND && i_ins_valid |=>
            i_ins_valid && $stable(i_ins_data) && $stable(i_ins_last))
    else begin
        $error("inserter accepted an input word in APPEND");
        fail_count++;
    end

    // Inserter output keeps valid up until its transfer
    hold_link_valid_a: assert property (@(posedge i_axi_aclk) disable iff (!i_axi_aresetn)
        i_link_valid && !i_link_ready |=> i_link_valid)
    else begin
        $error("inserter dropped valid before the transfer");
        fail_count++;
    end

endmodule : stream_checksum_checker

bind stream_checksum_top stream_checksum_checker u_checker (
    .i_axi_aclk    (i_axi_aclk),
    .i_axi_aresetn (i_axi_aresetn),
    .i_m_valid     (o_m_valid),
    .i_m_ready     (i_m_ready),
    .i_m_data      (o_m_data),
    .i_m_last      (o_m_last),
    .i_state       (u_inserter.r_state),
    .i_ins_valid   (link_in.valid),
    .i_ins_data    (link_in.data),
    .i_ins_last    (link_in.last),
    .i_link_valid  (link_out.valid),
    .i_link_ready  (link_out.ready)
);

/* verif/stream_scoreboard.sv */
`timescale 1ns/100ps

module stream_scoreboard import stream_pkg::*; (
    input  logic         i_axi_aclk,
    input  logic         i_axi_aresetn,
    input  logic         i_s_valid,
    input  logic         i_s_ready,
    input  stream_word_t i_s_data,
    input  logic         i_s_last,
    input  logic         i_m_valid,
    input  logic         i_m_ready,
    input  stream_word_t i_m_data,
    input  logic         i_m_last,
    input  logic         i_drain_check,
    output int           o_mismatches,
    output int           o_failures,
    output int           o_packets_out
);
    // Expected output words with the last mark in the top bit
    logic [$bits(stream_word_t):0] expected_q[$];
    logic [$bits(stream_word_t):0] head;
    checksum_t                     sum;
    logic                          in_reset_q;
    int                            blocked_cycles;

    initial begin
        o_mismatches   = 0;
        o_failures     = 0;
        o_packets_out  = 0;
        sum            = '0;
        in_reset_q     = 1'b0;
        blocked_cycles = 0;
    end

    always @(posedge i_axi_aclk) begin
        // Every edge that follows a low reset sample
        if (in_reset_q) begin
            if (i_s_ready !== 1'b0) begin
                o_mismatches++;
                $display("MISMATCH o_s_ready in reset: expected 0x0 actual 0x%0h", i_s_ready);
            end
            if (i_m_valid !== 1'b0) begin
                o_mismatches++;
                $display("MISMATCH o_m_valid in reset: expected 0x0 actual 0x%0h", i_m_valid);
            end
        end
        in_reset_q = !i_axi_aresetn;

        if (i_axi_aresetn) begin
            if (i_s_valid && i_s_ready) begin
                expected_q.push_back({1'b0, i_s_data});
                sum = sum + i_s_data;
                if (i_s_last) begin
                    expected_q.push_back({1'b1, sum});
                    sum = '0;
                end
            end
            if (i_s_valid && !i_s_ready) begin
                blocked_cycles++;
            end

            if (i_m_valid && i_m_ready) begin
                if (expected_q.size() == 0) begin
                    o_failures++;
                    $display("Output word 0x%08h left the DUT with nothing expected", i_m_data);
                end else begin
                    head = expected_q.pop_front();
                    if (i_m_data !== head[$bits(stream_word_t)-1:0]) begin
                        o_mismatches++;
                        $display("MISMATCH o_m_data: expected 0x%08h actual 0x%08h",
                                 head[$bits(stream_word_t)-1:0], i_m_data);
                    end
                    if (i_m_last !== head[$bits(stream_word_t)]) begin
                        o_mismatches++;
                        $display("MISMATCH o_m_last: expected 0x%0h actual 0x%0h",
                                 head[$bits(stream_word_t)], i_m_last);
                    end
                end
                if (i_m_last) begin
                    o_packets_out++;
                end
            end

            if (i_drain_check) begin
                if (expected_q.size() != 0) begin
                    o_failures++;
                    $display("%0d expected words never left the DUT", expected_q.size());
                end
                if (blocked_cycles == 0) begin
                    o_failures++;
                    $display("Input ready never fell under output back-pressure");
                end
            end
        end
    end

endmodule : stream_scoreboard

/* verif/tb_stream_checksum.sv */
`timescale 1ns/100ps

module tb_stream_checksum import stream_pkg::*; ();
    localparam int NUM_PACKETS    = 200;
    localparam int MAX_WORDS      = 16;
    localparam int CLK_PERIOD     = 40;
    localparam int TIMEOUT_CYCLES = NUM_PACKETS * (MAX_WORDS + 1) * 8;

    logic         clk;
    logic         aresetn;
    logic         s_valid;
    logic         s_ready;
    stream_word_t s_data;
    logic         s_last;
    logic         m_valid;
    logic         m_ready;
    stream_word_t m_data;
    logic         m_last;
    logic         drain_check;
    int           mismatches;
    int           failures;
    int           packets_out;
    int           stall_left;
    integer       seed;

    stream_checksum_top stream_checksum_top_i (
        .i_axi_aclk    (clk),
        .i_axi_aresetn (aresetn),
        .i_s_valid     (s_valid),
        .o_s_ready     (s_ready),
        .i_s_data      (s_data),
        .i_s_last      (s_last),
        .o_m_valid     (m_valid),
        .i_m_ready     (m_ready),
        .o_m_data      (m_data),
        .o_m_last      (m_last)
    );

    stream_scoreboard u_scoreboard (
        .i_axi_aclk    (clk),
        .i_axi_aresetn (aresetn),
        .i_s_valid     (s_valid),
        .i_s_ready     (s_ready),
        .i_s_data      (s_data),
        .i_s_last      (s_last),
        .i_m_valid     (m_valid),
        .i_m_ready     (m_ready),
        .i_m_data      (m_data),
        .i_m_last      (m_last),
        .i_drain_check (drain_check),
        .o_mismatches  (mismatches),
        .o_failures    (failures),
        .o_packets_out (packets_out)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Wait for the falling edge and draw a new output ready
    task automatic next_cycle();
        @(negedge clk);
        if (stall_left > 0) begin
            m_ready = 1'b0;
            stall_left--;
        end else begin
            m_ready = ($unsigned($random(seed)) % 10) < 7;
        end
    endtask

    task automatic send_word(input stream_word_t data, input logic last);
        while ($unsigned($random(seed)) % 4 == 0) begin
            s_valid = 1'b0;
            next_cycle();
        end
        s_valid = 1'b1;
        s_data  = data;
        s_last  = last;
        // Ready is a flop output, stable between edges
        while (!s_ready) begin
            next_cycle();
        end
        next_cycle();
        s_valid = 1'b0;
    endtask

    initial begin
        int len;
        clk         = 1'b0;
        aresetn     = 1'b0;
        s_valid     = 1'b0;
        s_data      = '0;
        s_last      = 1'b0;
        m_ready     = 1'b0;
        drain_check = 1'b0;
        stall_left  = 0;
        seed        = 32'hc529;
        repeat (4) next_cycle();
        aresetn = 1'b1;
        next_cycle();

        for (int pkt = 0; pkt < NUM_PACKETS; pkt++) begin
            // Long output stall now and then to fill both buffers
            if (pkt % 20 == 10) begin
                stall_left = 16;
            end
            len = 1 + ($unsigned($random(seed)) % MAX_WORDS);
            for (int w = 0; w < len; w++) begin
                send_word($random(seed), w == len - 1);
            end
        end

        while (packets_out < NUM_PACKETS) begin
            next_cycle();
        end
        drain_check = 1'b1;
        next_cycle();
        drain_check = 1'b0;
        next_cycle();

        $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatches, failures, stream_checksum_top_i.u_checker.fail_count);
        if (mismatches == 0 && failures == 0 &&
            stream_checksum_top_i.u_checker.fail_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Run timed out after %0d cycles with %0d of %0d packets out",
                 TIMEOUT_CYCLES, packets_out, NUM_PACKETS);
        $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatches, failures, stream_checksum_top_i.u_checker.fail_count);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule : tb_stream_checksum

/* flist.f */
+incdir+include
source/stream_pkg.sv
source/stream_if.sv
source/axi_skid_buffer.sv
source/checksum_inserter.sv
source/stream_checksum_top.sv
verif/stream_checksum_checker.sv
verif/stream_scoreboard.sv
verif/tb_stream_checksum.sv

/* Bender.yml */
package:
  name: stream_checksum

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/stream_pkg.sv
      - source/stream_if.sv
      - source/axi_skid_buffer.sv
      - source/checksum_inserter.sv
      - source/stream_checksum_top.sv
  - target: test
    files:
      - verif/stream_checksum_checker.sv
      - verif/stream_scoreboard.sv
      - verif/tb_stream_checksum.sv
